/* hdl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // datapath and instruction sizes
    localparam int dataWidth   = 8;
    localparam int addrWidth   = 8;
    localparam int instrWidth  = 16;
    localparam int regCount    = 16;
    localparam int regSelWidth = $clog2(regCount);

    // alu operations, low values shared with the immediate op field
    localparam logic [3:0] passB  = 4'd0;
    localparam logic [3:0] aluAnd = 4'd1;
    localparam logic [3:0] aluOr  = 4'd2;
    localparam logic [3:0] aluXor = 4'd3;
    localparam logic [3:0] aluAdd = 4'd4;
    localparam logic [3:0] aluSub = 4'd5;
    localparam logic [3:0] aluAdc = 4'd6;
    localparam logic [3:0] aluSbc = 4'd7;
    localparam logic [3:0] aluShl = 4'd8;
    localparam logic [3:0] aluShr = 4'd9;
    localparam logic [3:0] aluNot = 4'd10;
    localparam logic [3:0] aluInc = 4'd11;
    localparam logic [3:0] aluDec = 4'd12;
    localparam logic [3:0] passA  = 4'd13;

    // register-form function and sub-codes
    localparam logic [4:0] funcRegLast = 5'd12;
    localparam logic [4:0] funcJmp     = 5'b10110;
    localparam logic [4:0] funcHlt     = 5'b11101;
    localparam logic [2:0] subReg      = 3'b000;
    localparam logic [2:0] subIn       = 3'b010;
    localparam logic [2:0] subOut      = 3'b100;
    localparam logic [2:0] opInvalid   = 3'b111;  // imm flag with this op is not an alu op

    // jump condition codes
    localparam logic [2:0] condAlways = 3'd0;
    localparam logic [2:0] condC      = 3'd1;
    localparam logic [2:0] condNc     = 3'd2;
    localparam logic [2:0] condZ      = 3'd3;
    localparam logic [2:0] condNz     = 3'd4;
    localparam logic [2:0] condN      = 3'd5;
    localparam logic [2:0] condNn     = 3'd6;

    // datapath selectors
    localparam logic regSrcAlu = 1'b0;
    localparam logic regSrcIo  = 1'b1;
    localparam logic bSrcReg   = 1'b0;
    localparam logic bSrcImm   = 1'b1;

    localparam logic [1:0] addrSeq    = 2'd0;  // pc + 1
    localparam logic [1:0] addrSkip   = 2'd1;  // pc + 2
    localparam logic [1:0] addrTarget = 2'd2;  // low byte of the fetched word
    localparam logic [1:0] addrHold   = 2'd3;

    // controller states
    localparam logic [1:0] stBoot       = 2'd0;
    localparam logic [1:0] stExecute    = 2'd1;
    localparam logic [1:0] stIoWait     = 2'd2;
    localparam logic [1:0] stJumpTarget = 2'd3;

    typedef struct packed {
        logic [regSelWidth-1:0] dst;
        logic [dataWidth-1:0]   imm;      // immediate or port number
        logic [2:0]             op;
        logic                   immFlag;
    } immForm_t;

    typedef struct packed {
        logic [regSelWidth-1:0] dst;      // top three bits are the jump condition
        logic [regSelWidth-1:0] src;
        logic [4:0]             func;
        logic [2:0]             sub;
    } regForm_t;

    // every word is looked at both ways during decode
    typedef union packed {
        immForm_t iForm;
        regForm_t rForm;
    } instrWord_u;

endpackage

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic                   clk,
    input  logic [regSelWidth-1:0] selA,
    input  logic [regSelWidth-1:0] selB,
    input  logic                   writeEn,
    input  logic [dataWidth-1:0]   writeData,
    output logic [dataWidth-1:0]   regA,
    output logic [dataWidth-1:0]   regB
);

    logic [dataWidth-1:0] regs [regCount];

    // write port shares the A index
    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[selA] <= writeData;
        end
    end

    assign regA = regs[selA];
    assign regB = regs[selB];

endmodule

`default_nettype wire

/* hdl/aluFlags.sv */
`default_nettype none
`timescale 1ns/1ps

module aluFlags import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [3:0]           aluMode,
    input  logic                 bSrc,
    input  logic [dataWidth-1:0] regA,
    input  logic [dataWidth-1:0] regB,
    input  logic [dataWidth-1:0] imm,
    input  logic                 flagEnable,
    output logic [dataWidth-1:0] aluResult,
    output logic                 carry,
    output logic                 zero,
    output logic                 negative
);

    logic [dataWidth-1:0] opB;
    logic [dataWidth:0]   wide;  // top bit is carry out or borrow
    logic                 carryNext;

    assign opB = (bSrc == bSrcImm) ? imm : regB;

    always_comb begin
        wide      = {1'b0, opB};
        carryNext = carry;  // logic ops leave carry alone
        case (aluMode)
            aluAnd: wide = {1'b0, regA & opB};
            aluOr:  wide = {1'b0, regA | opB};
            aluXor: wide = {1'b0, regA ^ opB};
            aluAdd: begin
                wide      = regA + opB;
                carryNext = wide[dataWidth];
            end
            aluSub: begin
                wide      = regA - opB;
                carryNext = wide[dataWidth];  // borrow
            end
            aluAdc: begin
                wide      = regA + opB + carry;
                carryNext = wide[dataWidth];
            end
            aluSbc: begin
                wide      = regA - opB - carry;
                carryNext = wide[dataWidth];
            end
            aluShl: begin
                wide      = {regA, 1'b0};
                carryNext = regA[dataWidth-1];
            end
            aluShr: begin
                wide      = {2'b00, regA[dataWidth-1:1]};
                carryNext = regA[0];
            end
            aluNot: wide = {1'b0, ~regA};
            aluInc: wide = {1'b0, regA + 1'b1};
            aluDec: wide = {1'b0, regA - 1'b1};
            passA:  wide = {1'b0, regA};
            default: wide = {1'b0, opB};  // passB
        endcase
    end

    assign aluResult = wide[dataWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            carry    <= 1'b0;
            zero     <= 1'b0;
            negative <= 1'b0;
        end else if (flagEnable) begin
            carry    <= carryNext;
            zero     <= (aluResult == '0);
            negative <= aluResult[dataWidth-1];
        end
    end

    flagsHeld: assert property (@(posedge clk) disable iff (!rstN)
        (!$past(flagEnable) && $past(rstN)) |-> $stable({carry, zero, negative}))
        else $error("flags changed without flagEnable");

endmodule

`default_nettype wire

/* hdl/fetchUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 fetchEn,
    input  logic [1:0]           addrSelect,
    input  logic [addrWidth-1:0] target,
    output logic [addrWidth-1:0] iMemAddr
);

    logic [addrWidth-1:0] pc;  // address of the word now on iMemData

    always_comb begin
        case (addrSelect)
            addrSeq:    iMemAddr = pc + 1'b1;
            addrSkip:   iMemAddr = pc + 2'd2;  // step over the jump target word
            addrTarget: iMemAddr = target;
            addrHold:   iMemAddr = pc;
        endcase
    end

    // all ones so the first fetch lands on 0
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '1;
        end else if (fetchEn) begin
            pc <= iMemAddr;
        end
    end

    pcOnlyOnFetch: assert property (@(posedge clk) disable iff (!rstN)
        $changed(pc) |-> ($past(fetchEn) || !$past(rstN)))
        else $error("pc changed without fetchEn");

endmodule

`default_nettype wire

/* hdl/controlUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  instrWord_u instr,
    input  logic       carry,
    input  logic       zero,
    input  logic       negative,
    output logic       regWriteEn,
    output logic       regWriteSrc,
    output logic       bSrc,
    output logic [3:0] aluMode,
    output logic       flagEnable,
    output logic       ioReadEn,
    output logic       ioWriteEn,
    output logic       fetchEn,
    output logic [1:0] addrSelect
);

    logic [1:0] state;
    logic [1:0] nextState;
    logic [2:0] cond;
    logic       condMet;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stBoot;
        end else begin
            state <= nextState;
        end
    end

    assign cond = instr.rForm.dst[regSelWidth-1:1];

    always_comb begin
        case (cond)
            condC:   condMet = carry;
            condNc:  condMet = !carry;
            condZ:   condMet = zero;
            condNz:  condMet = !zero;
            condN:   condMet = negative;
            condNn:  condMet = !negative;
            default: condMet = 1'b1;  // condAlways and the spare code
        endcase
    end

    always_comb begin
        regWriteEn  = 1'b0;
        regWriteSrc = regSrcAlu;
        bSrc        = bSrcReg;
        aluMode     = passB;
        flagEnable  = 1'b0;
        ioReadEn    = 1'b0;
        ioWriteEn   = 1'b0;
        fetchEn     = 1'b0;
        addrSelect  = addrHold;
        nextState   = stExecute;

        case (state)
            stBoot: begin
                fetchEn    = 1'b1;  // pc wraps from all ones to 0
                addrSelect = addrSeq;
            end
            stIoWait: begin
                regWriteEn  = 1'b1;
                regWriteSrc = regSrcIo;
                fetchEn     = 1'b1;
                addrSelect  = addrSeq;
            end
            stJumpTarget: begin
                fetchEn    = 1'b1;  // word on the bus is the target
                addrSelect = addrTarget;
            end
            default: begin
                if (instr.iForm.immFlag && instr.iForm.op != opInvalid) begin
                    regWriteEn = 1'b1;
                    bSrc       = bSrcImm;
                    aluMode    = {1'b0, instr.iForm.op};
                    flagEnable = (instr.iForm.op != passB[2:0]);  // load-immediate keeps flags
                    fetchEn    = 1'b1;
                    addrSelect = addrSeq;
                end else if (instr.rForm.sub == subIn) begin
                    ioReadEn  = 1'b1;  // data comes back next cycle
                    nextState = stIoWait;
                end else if (instr.rForm.sub == subOut) begin
                    ioWriteEn  = 1'b1;
                    fetchEn    = 1'b1;
                    addrSelect = addrSeq;
                end else if (instr.rForm.func != 5'd0 && instr.rForm.func <= funcRegLast &&
                             instr.rForm.sub == subReg) begin
                    regWriteEn = 1'b1;
                    aluMode    = instr.rForm.func[3:0];
                    flagEnable = 1'b1;
                    fetchEn    = 1'b1;
                    addrSelect = addrSeq;
                end else if (instr.rForm.func == funcJmp) begin
                    fetchEn = 1'b1;
                    if (condMet) begin
                        addrSelect = addrSeq;  // read the target word
                        nextState  = stJumpTarget;
                    end else begin
                        addrSelect = addrSkip;
                    end
                end else if (instr.rForm.func == funcHlt && instr.rForm.sub == subReg) begin
                    addrSelect = addrHold;  // no fetch, word stays on the bus
                end else begin
                    fetchEn    = 1'b1;  // nop
                    addrSelect = addrSeq;
                end
            end
        endcase
    end

    ioStrobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(ioReadEn && ioWriteEn))
        else $error("io read and write strobes high together");

    // IN stalls fetch for one cycle, then writes back and resumes
    inSequence: assert property (@(posedge clk) disable iff (!rstN)
        ioReadEn |-> !fetchEn ##1 (state == stIoWait && regWriteEn && fetchEn && !ioReadEn))
        else $error("IN sequence broken");

endmodule

`default_nettype wire

/* hdl/cpuCore.sv */
`default_nettype none
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic [instrWidth-1:0] iMemData,
    output logic [addrWidth-1:0]  iMemAddr,
    output logic                  iMemReadEn,
    output logic [dataWidth-1:0]  ioAddr,
    output logic [dataWidth-1:0]  ioWriteData,
    input  logic [dataWidth-1:0]  ioReadData,
    output logic                  ioReadEn,
    output logic                  ioWriteEn
);

    instrWord_u           instr;
    logic                 regWriteEn;
    logic                 regWriteSrc;
    logic                 bSrc;
    logic [3:0]           aluMode;
    logic                 flagEnable;
    logic                 fetchEn;
    logic [1:0]           addrSelect;
    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] regWriteData;
    logic [dataWidth-1:0] aluResult;
    logic                 carry;
    logic                 zero;
    logic                 negative;

    assign instr        = iMemData;
    assign regWriteData = (regWriteSrc == regSrcIo) ? ioReadData : aluResult;
    assign ioAddr       = instr.iForm.imm;  // port number field
    assign ioWriteData  = regA;
    assign iMemReadEn   = fetchEn;

    controlUnit uControl (
        .clk         (clk),
        .rstN        (rstN),
        .instr       (instr),
        .carry       (carry),
        .zero        (zero),
        .negative    (negative),
        .regWriteEn  (regWriteEn),
        .regWriteSrc (regWriteSrc),
        .bSrc        (bSrc),
        .aluMode     (aluMode),
        .flagEnable  (flagEnable),
        .ioReadEn    (ioReadEn),
        .ioWriteEn   (ioWriteEn),
        .fetchEn     (fetchEn),
        .addrSelect  (addrSelect)
    );

    regFile uRegFile (
        .clk       (clk),
        .selA      (instr.rForm.dst),
        .selB      (instr.rForm.src),
        .writeEn   (regWriteEn),
        .writeData (regWriteData),
        .regA      (regA),
        .regB      (regB)
    );

    aluFlags uAlu (
        .clk        (clk),
        .rstN       (rstN),
        .aluMode    (aluMode),
        .bSrc       (bSrc),
        .regA       (regA),
        .regB       (regB),
        .imm        (instr.iForm.imm),
        .flagEnable (flagEnable),
        .aluResult  (aluResult),
        .carry      (carry),
        .zero       (zero),
        .negative   (negative)
    );

    fetchUnit uFetch (
        .clk        (clk),
        .rstN       (rstN),
        .fetchEn    (fetchEn),
        .addrSelect (addrSelect),
        .target     (iMemData[addrWidth-1:0]),  // jump target word, low byte
        .iMemAddr   (iMemAddr)
    );

endmodule

`default_nettype wire

/* dv/cpuCoreTb.sv */
`default_nettype none
`timescale 1ns/1ps

module cpuCoreTb import cpuPkg::*; ();

    logic                  clk = 1'b0;
    logic                  rstN;
    logic [instrWidth-1:0] iMemData;
    logic [addrWidth-1:0]  iMemAddr;
    logic                  iMemReadEn;
    logic [dataWidth-1:0]  ioAddr;
    logic [dataWidth-1:0]  ioWriteData;
    logic [dataWidth-1:0]  ioReadData;
    logic                  ioReadEn;
    logic                  ioWriteEn;

    // program image with per-address expectations
    logic [instrWidth-1:0] mem [2**addrWidth];
    int                    testOf [2**addrWidth];
    bit                    isOut [2**addrWidth];
    logic [dataWidth-1:0]  expOut [2**addrWidth];
    logic [dataWidth-1:0]  expPort [2**addrWidth];
    bit                    checkFetch [2**addrWidth];
    logic [addrWidth-1:0]  expFetch [2**addrWidth];

    logic [dataWidth-1:0]  mReg [regCount];  // reference registers
    logic                  mC;
    logic                  mZ;
    logic                  mN;

    logic [addrWidth-1:0]  curAddr;  // address of the word on iMemData
    logic [addrWidth-1:0]  hltAddr;
    logic [addrWidth-1:0]  fetchAddr;
    logic [dataWidth-1:0]  portNum;
    logic                  fetchReq;
    logic                  portReq;
    integer                seed = 32'h32fb;
    int                    progLen;
    int                    buildTest;
    int                    curTest;
    int                    errCount [1:6];
    string                 testName [1:6];
    bit                    booted;
    bit                    built;

    cpuCore DUT (
        .clk         (clk),
        .rstN        (rstN),
        .iMemData    (iMemData),
        .iMemAddr    (iMemAddr),
        .iMemReadEn  (iMemReadEn),
        .ioAddr      (ioAddr),
        .ioWriteData (ioWriteData),
        .ioReadData  (ioReadData),
        .ioReadEn    (ioReadEn),
        .ioWriteEn   (ioWriteEn)
    );

    always #4 clk = ~clk;

    // program memory and port device answer 1 ns after the edge
    always @(posedge clk) begin
        fetchReq  = iMemReadEn;
        fetchAddr = iMemAddr;
        portReq   = ioReadEn;
        portNum   = ioAddr;
        #1;
        if (fetchReq === 1'b1) begin
            iMemData = mem[fetchAddr];
            curAddr  = fetchAddr;
        end
        if (portReq === 1'b1) begin
            ioReadData = portNum ^ 8'hA5;
        end
    end

    always @(posedge clk) begin
        if (!rstN) begin
            booted <= 1'b0;
        end else if (iMemReadEn) begin
            booted <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (booted && testOf[curAddr] != curTest) begin
            reportTest(curTest);
            curTest = testOf[curAddr];
        end
    end

    task automatic logError(input string line);
        errCount[testOf[curAddr]]++;
        $display("%s", line);
    endtask

    task automatic reportTest(input int t);
        $display("test %0d %s: %s, %0d error(s)", t, testName[t],
                 (errCount[t] == 0) ? "passed" : "failed", errCount[t]);
    endtask

    firstFetchAtZero: assert property (@(posedge clk)
        (rstN && !booted && iMemReadEn) |-> iMemAddr == '0)
        else logError($sformatf("MISMATCH at %0t: first fetch address %h, expected 00",
                                $time, $sampled(iMemAddr)));

    noIoBeforeBoot: assert property (@(posedge clk)
        (rstN && !booted) |-> !ioReadEn && !ioWriteEn)
        else logError($sformatf("ERROR at %0t: I/O strobe before the first fetch", $time));

    outValue: assert property (@(posedge clk) disable iff (!rstN)
        ioWriteEn |-> isOut[curAddr] && ioWriteData == expOut[curAddr] &&
                      ioAddr == expPort[curAddr])
        else logError($sformatf("MISMATCH at %0t: OUT at %h wrote %h to port %h, expected %h to %h",
                                $time, $sampled(curAddr), $sampled(ioWriteData),
                                $sampled(ioAddr), expOut[$sampled(curAddr)],
                                expPort[$sampled(curAddr)]));

    outStrobe: assert property (@(posedge clk) disable iff (!rstN)
        (booted && isOut[curAddr]) |-> ioWriteEn)
        else logError($sformatf("ERROR at %0t: OUT at %h raised no ioWriteEn", $time,
                                $sampled(curAddr)));

    inSingleCycle: assert property (@(posedge clk) disable iff (!rstN)
        ioReadEn |=> !ioReadEn)
        else logError($sformatf("ERROR at %0t: ioReadEn held for more than one cycle", $time));

    jumpFetch: assert property (@(posedge clk) disable iff (!rstN)
        (iMemReadEn && checkFetch[curAddr]) |-> iMemAddr == expFetch[curAddr])
        else logError($sformatf("MISMATCH at %0t: fetch after %h went to %h, expected %h",
                                $time, $sampled(curAddr), $sampled(iMemAddr),
                                expFetch[$sampled(curAddr)]));

    haltQuiet: assert property (@(posedge clk) disable iff (!rstN)
        (curAddr == hltAddr) |-> !iMemReadEn && !ioReadEn && !ioWriteEn)
        else logError($sformatf("ERROR at %0t: fetch or I/O strobe after HLT", $time));

    function automatic logic [31:0] nextRand();
        return $random(seed);
    endfunction

    function automatic bit condHolds(input logic [2:0] cond);
        case (cond)
            condC:   return mC;
            condNc:  return !mC;
            condZ:   return mZ;
            condNz:  return !mZ;
            condN:   return mN;
            condNn:  return !mN;
            default: return 1'b1;
        endcase
    endfunction

    // reference ALU works on integers and keeps the low byte
    task automatic applyModel(input logic [3:0] mode, input logic [3:0] d,
                              input logic [7:0] b, input bit setFlags);
        int   a;
        int   r;
        logic c;
        a = mReg[d];
        case (mode)
            passB:   r = b;
            aluAnd:  r = a & b;
            aluOr:   r = a | b;
            aluXor:  r = a ^ b;
            aluAdd:  r = a + b;
            aluSub:  r = a - b;
            aluAdc:  r = a + b + mC;
            aluSbc:  r = a - b - mC;
            aluShl:  r = a * 2;
            aluShr:  r = a / 2;
            aluNot:  r = 255 - a;
            aluInc:  r = a + 1;
            aluDec:  r = a - 1;
            default: r = a;
        endcase
        case (mode)
            aluAdd, aluAdc: c = (r > 255);
            aluSub, aluSbc: c = (r < 0);  // borrow shows as a negative difference
            aluShl:         c = (a >= 128);
            aluShr:         c = (a % 2 == 1);
            default:        c = mC;
        endcase
        mReg[d] = r[7:0];
        if (setFlags) begin
            mC = c;
            mZ = (r[7:0] == 8'h00);
            mN = r[7];
        end
    endtask

    task automatic appendWord(input logic [15:0] w);
        mem[progLen]    = w;
        testOf[progLen] = buildTest;
        progLen++;
    endtask

    task automatic loadImm(input logic [3:0] r, input logic [7:0] v);
        appendWord({r, v, passB[2:0], 1'b1});
        applyModel(passB, r, v, 1'b0);  // load leaves flags alone
    endtask

    task automatic immOp(input logic [3:0] r, input logic [2:0] op, input logic [7:0] v);
        appendWord({r, v, op, 1'b1});
        applyModel({1'b0, op}, r, v, 1'b1);
    endtask

    task automatic regOp(input logic [3:0] d, input logic [3:0] s, input logic [3:0] mode);
        appendWord({d, s, 1'b0, mode, subReg});
        applyModel(mode, d, mReg[s], 1'b1);
    endtask

    task automatic outReg(input logic [3:0] r, input logic [7:0] p);
        isOut[progLen]   = 1'b1;
        expOut[progLen]  = mReg[r];
        expPort[progLen] = p;
        appendWord({r, p, 1'b0, subOut});
    endtask

    task automatic inPort(input logic [3:0] r, input logic [7:0] p);
        appendWord({r, p, 1'b0, subIn});
        mReg[r] = p ^ 8'hA5;
    endtask

    task automatic regCase(input logic [3:0] d, input logic [3:0] s, input logic [3:0] mode,
                           input logic [7:0] a, input logic [7:0] b);
        loadImm(d, a);
        loadImm(s, b);
        regOp(d, s, mode);
        outReg(d, nextRand());
    endtask

    // jump word, target word, then a NOP the taken path steps over
    task automatic jumpIf(input logic [2:0] cond);
        int a;
        a = progLen;
        checkFetch[a] = 1'b1;
        if (condHolds(cond)) begin
            expFetch[a]       = a + 1;
            checkFetch[a + 1] = 1'b1;
            expFetch[a + 1]   = a + 3;
        end else begin
            expFetch[a] = a + 2;
        end
        appendWord({cond, 1'b0, 4'h0, funcJmp, subReg});
        appendWord({8'h00, 8'(a + 3)});
        appendWord(16'h0000);
    endtask

    task automatic buildProgram();
        logic [3:0] r;
        logic [3:0] s;
        for (int i = 0; i < 2**addrWidth; i++) begin
            mem[i]        = '0;
            isOut[i]      = 1'b0;
            checkFetch[i] = 1'b0;
            testOf[i]     = 6;
        end
        mC = 1'b0;
        mZ = 1'b0;
        mN = 1'b0;
        buildTest = 1;
        appendWord(16'h0000);  // boot lands on a NOP
        buildTest = 2;
        repeat (12) begin
            r = nextRand();
            loadImm(r, nextRand());
            immOp(r, 3'(1 + nextRand() % 6), nextRand());
            outReg(r, nextRand());
        end
        buildTest = 3;
        regCase(4'd2, 4'd3, aluAdd, 8'hF0, 8'h20);
        regCase(4'd4, 4'd5, aluSub, 8'h10, 8'h20);
        regCase(4'd6, 4'd7, aluShl, 8'h81, 8'h00);
        regCase(4'd8, 4'd9, aluShr, 8'h03, 8'h00);
        for (int f = 1; f <= funcRegLast; f++) begin
            r = nextRand();
            s = r + 4'(1 + nextRand() % 15);
            regCase(r, s, 4'(f), nextRand(), nextRand());
        end
        buildTest = 4;
        repeat (4) begin
            r = nextRand();
            inPort(r, nextRand());
            outReg(r, nextRand());
        end
        buildTest = 5;
        for (int c = condAlways; c <= condNn; c++) begin
            for (int k = 0; k < 2; k++) begin
                loadImm(4'd1, 8'(k));  // 0 - 1 sets C and N, 1 - 1 sets Z
                loadImm(4'd2, 8'h01);
                regOp(4'd1, 4'd2, aluSub);
                jumpIf(3'(c));
            end
        end
        buildTest = 6;
        hltAddr = progLen;
        appendWord({8'h00, funcHlt, subReg});
    endtask

    initial begin
        wait (built);
        #((progLen * 4 + 100) * 8);
        $display("timeout: the program did not reach HLT in time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int errTotal;
        int failedTests;
        rstN       = 1'b0;
        iMemData   = '0;
        ioReadData = '0;
        curAddr    = '0;
        curTest    = 1;
        progLen    = 0;
        testName[1] = "boot fetch";
        testName[2] = "immediate ops";
        testName[3] = "register ops";
        testName[4] = "port input";
        testName[5] = "conditional jumps";
        testName[6] = "halt";
        buildProgram();
        built = 1'b1;
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        while (!(booted && curAddr == hltAddr)) @(posedge clk);
        repeat (20) @(posedge clk);  // stay in HLT a while
        reportTest(curTest);
        errTotal    = 0;
        failedTests = 0;
        for (int t = 1; t <= 6; t++) begin
            errTotal += errCount[t];
            if (errCount[t] != 0) begin
                failedTests++;
            end
        end
        $display("%0d of 6 tests failed, %0d errors", failedTests, errTotal);
        if (errTotal == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpuCore.f */
hdl/cpuPkg.sv
hdl/regFile.sv
hdl/aluFlags.sv
hdl/fetchUnit.sv
hdl/controlUnit.sv
hdl/cpuCore.sv
dv/cpuCoreTb.sv
